// ==== Makefile ====
# Verilator flow for the three-stage pipeline testbench

TOP := tb_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module hzd_core \
		verilog/hzd_pkg.sv verilog/hzd_regfile.sv verilog/hzd_bypass_ctrl.sv \
		verilog/hzd_id_stage.sv verilog/hzd_ex_stage.sv verilog/hzd_wb_stage.sv \
		verilog/hzd_core.sv

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

// ==== bench/tb_core.sv ====
/*
 * Testbench for the three-stage pipeline. Sends directed and random
 * instruction streams, keeps a shadow register file and checks every
 * write-back as well as the data memory handshake
 */
`timescale 1ns/1ps

module tb_core;

  // Same read data rule as the memory model
  localparam hzd_pkg::xlen_t RDATA_MASK = 32'h5a5a_0000;
  localparam int ACCEPT_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT  = 400;
  localparam int RANDOM_COUNT   = 200;

  logic              clk;
  logic              rst;
  logic              instr_valid;
  hzd_pkg::op_e      instr_op;
  hzd_pkg::rf_addr_t instr_rd;
  hzd_pkg::rf_addr_t instr_rs1;
  hzd_pkg::rf_addr_t instr_rs2;
  hzd_pkg::xlen_t    instr_imm;
  logic              instr_ready;
  logic              mem_req;
  hzd_pkg::xlen_t    mem_addr;
  logic              mem_ack;
  hzd_pkg::xlen_t    mem_rdata;
  logic              wb_valid;
  hzd_pkg::rf_addr_t wb_rd;
  hzd_pkg::xlen_t    wb_data;

  // Handshake signals as seen at the previous edge
  logic              req_q;
  logic              ack_q;
  hzd_pkg::xlen_t    addr_q;

  // Shadow register file and the writes still expected in program order
  hzd_pkg::xlen_t    shadow [32];
  hzd_pkg::rf_addr_t exp_rd [$];
  hzd_pkg::xlen_t    exp_data [$];
  string             exp_test [$];
  // Load addresses still expected on the memory port
  hzd_pkg::xlen_t    exp_addr [$];
  string             test_name;
  integer            seed;

  hzd_core u_dut (
    .clk_i         (clk),
    .rst_i         (rst),
    .instr_valid_i (instr_valid),
    .op_i          (instr_op),
    .rd_i          (instr_rd),
    .rs1_i         (instr_rs1),
    .rs2_i         (instr_rs2),
    .imm_i         (instr_imm),
    .instr_ready_o (instr_ready),
    .mem_req_o     (mem_req),
    .mem_addr_o    (mem_addr),
    .mem_ack_i     (mem_ack),
    .mem_rdata_i   (mem_rdata),
    .wb_valid_o    (wb_valid),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data)
  );

  tb_mem_model #(
    .SEED (32'ha3e5)
  ) u_mem (
    .clk_i   (clk),
    .rst_i   (rst),
    .req_i   (mem_req),
    .addr_i  (mem_addr),
    .ack_o   (mem_ack),
    .rdata_o (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules and error reporting
  ////////////////////////////////////////////////////////////////////////////

  // Expected result of each opcode
  // A load returns the memory rule applied to rs1 + imm
  function automatic hzd_pkg::xlen_t expected_result(input hzd_pkg::op_e op,
                                                     input hzd_pkg::xlen_t a,
                                                     input hzd_pkg::xlen_t b,
                                                     input hzd_pkg::xlen_t imm);
    case (op)
      hzd_pkg::OP_ADD:  return a + b;
      hzd_pkg::OP_ADDI: return a + imm;
      default:          return (a + imm) ^ RDATA_MASK;
    endcase
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic report_mismatch(input string test, input string field,
                                 input hzd_pkg::xlen_t expected,
                                 input hzd_pkg::xlen_t actual);
    abort_run($sformatf("CHECK FAILED test=%s %s expected=0x%08h actual=0x%08h",
                        test, field, expected, actual));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Register zero never changes, so it gets no entry in the expected queue
  // Every load still accesses memory, whatever its destination
  task automatic accept_in_model(input hzd_pkg::op_e op, input hzd_pkg::rf_addr_t rd,
                                 input hzd_pkg::rf_addr_t rs1,
                                 input hzd_pkg::rf_addr_t rs2,
                                 input hzd_pkg::xlen_t imm);
    hzd_pkg::xlen_t value;
    value = expected_result(op, shadow[rs1], shadow[rs2], imm);
    if (op == hzd_pkg::OP_LOAD) begin
      exp_addr.push_back(shadow[rs1] + imm);
    end
    if (rd != '0) begin
      shadow[rd] = value;
      exp_rd.push_back(rd);
      exp_data.push_back(value);
      exp_test.push_back(test_name);
    end
  endtask

  // Holds the instruction on the port until an edge sees ready high
  task automatic send_instr(input hzd_pkg::op_e op, input hzd_pkg::rf_addr_t rd,
                            input hzd_pkg::rf_addr_t rs1, input hzd_pkg::rf_addr_t rs2,
                            input hzd_pkg::xlen_t imm);
    int waited;
    instr_valid <= 1'b1;
    instr_op    <= op;
    instr_rd    <= rd;
    instr_rs1   <= rs1;
    instr_rs2   <= rs2;
    instr_imm   <= imm;
    waited = 0;
    @(posedge clk);
    while (!instr_ready) begin
      if (waited == ACCEPT_TIMEOUT) begin
        abort_run($sformatf("Timeout: no instruction accepted for %0d cycles in test %s",
                            ACCEPT_TIMEOUT, test_name));
      end else begin
        @(posedge clk);
        waited++;
      end
    end
    accept_in_model(op, rd, rs1, rs2, imm);
  endtask

  task automatic idle_cycles(input int count);
    instr_valid <= 1'b0;
    repeat (count) @(posedge clk);
  endtask

  // Waits until every expected write-back and load access has been seen
  task automatic drain_writes();
    int waited;
    instr_valid <= 1'b0;
    waited = 0;
    while ((exp_rd.size() != 0) || (exp_addr.size() != 0)) begin
      if (waited == DRAIN_TIMEOUT) begin
        abort_run($sformatf("Timeout: %0d writes and %0d loads missing in test %s",
                            exp_rd.size(), exp_addr.size(), test_name));
      end else begin
        @(posedge clk);
        waited++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////////////////////

  // Each observed write must be the oldest outstanding one
  always @(posedge clk) begin
    if (!rst && wb_valid) begin
      if (exp_rd.size() == 0) begin
        abort_run($sformatf("Write-back to x%0d with no instruction outstanding in test %s",
                            wb_rd, test_name));
      end else begin
        assert (wb_rd == exp_rd[0])
          else report_mismatch(exp_test[0], "wb_rd_o", {27'd0, exp_rd[0]}, {27'd0, wb_rd});
        assert (wb_data == exp_data[0])
          else report_mismatch(exp_test[0], "wb_data_o", exp_data[0], wb_data);
        void'(exp_rd.pop_front());
        void'(exp_data.pop_front());
        void'(exp_test.pop_front());
      end
    end
  end

  // Four-phase order on the data memory port
  always @(posedge clk) begin
    if (rst) begin
      req_q <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      if (req_q && !mem_req) begin
        assert (ack_q) else abort_run("mem_req_o dropped before mem_ack_i rose");
      end
      // Each new access must carry the address of the oldest load not yet sent
      if (!req_q && mem_req) begin
        assert (!mem_ack) else abort_run("mem_req_o rose while mem_ack_i was still high");
        if (exp_addr.size() == 0) begin
          abort_run("mem_req_o rose with no load outstanding");
        end else begin
          assert (mem_addr == exp_addr[0])
            else report_mismatch(test_name, "mem_addr_o", exp_addr[0], mem_addr);
          void'(exp_addr.pop_front());
        end
      end
      // The address may not move while req is held
      if (req_q && mem_req) begin
        assert (mem_addr == addr_q)
          else report_mismatch(test_name, "mem_addr_o", addr_q, mem_addr);
      end
      req_q  <= mem_req;
      ack_q  <= mem_ack;
      addr_q <= mem_addr;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    hzd_pkg::op_e      r_op;
    hzd_pkg::rf_addr_t r_rd;
    hzd_pkg::rf_addr_t r_rs1;
    hzd_pkg::rf_addr_t r_rs2;
    hzd_pkg::xlen_t    r_imm;
    seed = 32'ha3e5;
    shadow = '{default: '0};
    test_name = "reset";
    rst         <= 1'b1;
    instr_valid <= 1'b0;
    instr_op    <= hzd_pkg::OP_ADD;
    instr_rd    <= '0;
    instr_rs1   <= '0;
    instr_rs2   <= '0;
    instr_imm   <= '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (instr_ready) else report_mismatch(test_name, "instr_ready_o", 32'd1, 32'd0);
    assert (!mem_req) else report_mismatch(test_name, "mem_req_o", 32'd0, 32'd1);
    assert (!wb_valid) else report_mismatch(test_name, "wb_valid_o", 32'd0, 32'd1);

    // Each add reads the result of the one right before it
    test_name = "ex_forward";
    send_instr(hzd_pkg::OP_ADDI, 5'd1, 5'd0, 5'd0, 32'd5);
    send_instr(hzd_pkg::OP_ADD, 5'd2, 5'd1, 5'd1, 32'd0);
    send_instr(hzd_pkg::OP_ADD, 5'd3, 5'd2, 5'd1, 32'd0);
    send_instr(hzd_pkg::OP_ADDI, 5'd3, 5'd3, 5'd0, 32'hffff_fff0);
    drain_writes();

    // x4 and x7 come from WB, x5 from EX at the same time
    test_name = "wb_forward";
    send_instr(hzd_pkg::OP_ADDI, 5'd4, 5'd0, 5'd0, 32'h1234);
    send_instr(hzd_pkg::OP_ADDI, 5'd5, 5'd0, 5'd0, 32'd9);
    send_instr(hzd_pkg::OP_ADD, 5'd6, 5'd4, 5'd5, 32'd0);
    send_instr(hzd_pkg::OP_ADDI, 5'd7, 5'd3, 5'd0, 32'd1);
    send_instr(hzd_pkg::OP_ADDI, 5'd8, 5'd0, 5'd0, 32'd2);
    send_instr(hzd_pkg::OP_ADD, 5'd9, 5'd7, 5'd7, 32'd0);
    drain_writes();

    test_name = "load_use";
    send_instr(hzd_pkg::OP_LOAD, 5'd10, 5'd1, 5'd0, 32'h100);
    send_instr(hzd_pkg::OP_ADDI, 5'd11, 5'd10, 5'd0, 32'd3);
    send_instr(hzd_pkg::OP_LOAD, 5'd12, 5'd11, 5'd0, 32'd4);
    send_instr(hzd_pkg::OP_ADD, 5'd13, 5'd12, 5'd12, 32'd0);
    drain_writes();

    // Chained loads keep the memory busy under random ack timing
    test_name = "mem_handshake";
    for (int i = 0; i < 8; i++) begin
      send_instr(hzd_pkg::OP_LOAD, 5'd14, 5'd14, 5'd0, i * 4);
      send_instr(hzd_pkg::OP_ADD, 5'd15, 5'd15, 5'd14, 32'd0);
    end
    drain_writes();

    test_name = "reg_zero";
    send_instr(hzd_pkg::OP_ADDI, 5'd0, 5'd1, 5'd0, 32'd1);
    send_instr(hzd_pkg::OP_LOAD, 5'd0, 5'd1, 5'd0, 32'h40);
    send_instr(hzd_pkg::OP_ADD, 5'd16, 5'd0, 5'd0, 32'd0);
    send_instr(hzd_pkg::OP_ADDI, 5'd17, 5'd0, 5'd0, 32'd77);
    drain_writes();

    // Seeded mix of all opcodes with an occasional idle cycle
    test_name = "random";
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      r_op  = hzd_pkg::op_e'($unsigned($random(seed)) % 3);
      r_rd  = hzd_pkg::rf_addr_t'($random(seed));
      r_rs1 = hzd_pkg::rf_addr_t'($random(seed));
      r_rs2 = hzd_pkg::rf_addr_t'($random(seed));
      r_imm = $random(seed);
      send_instr(r_op, r_rd, r_rs1, r_rs2, r_imm);
      if (($random(seed) & 7) == 0) begin
        idle_cycles(1);
      end
    end
    drain_writes();

    // Quiet cycles expose any late or spurious write-back or memory request
    idle_cycles(10);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== bench/tb_mem_model.sv ====
/*
 * Data memory responder for the four-phase load port. Ack follows req
 * and its release after random delays; read data comes from the address
 */
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int SEED = 32'ha3e5
) (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           req_i,
  input  hzd_pkg::xlen_t addr_i,
  output logic           ack_o,
  output hzd_pkg::xlen_t rdata_o
);

  // Every address reads back as itself with this pattern applied
  localparam hzd_pkg::xlen_t RDATA_MASK = 32'h5a5a_0000;

  // Longest wait in cycles before ack rises or falls
  localparam int MAX_DELAY = 4;

  integer seed;
  int     delay;

  initial begin
    seed = SEED;
    ack_o   <= 1'b0;
    rdata_o <= '0;
    forever begin
      @(posedge clk_i);
      if (rst_i) begin
        ack_o <= 1'b0;
      end else if (req_i && !ack_o) begin
        // In phase 2 the address stays stable as long as req is high
        delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
        repeat (delay) @(posedge clk_i);
        ack_o   <= 1'b1;
        rdata_o <= addr_i ^ RDATA_MASK;
      end else if (!req_i && ack_o) begin
        // Phase 4 closes the access
        delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
        repeat (delay) @(posedge clk_i);
        ack_o <= 1'b0;
      end
    end
  end

endmodule

// ==== sim.f ====
verilog/hzd_pkg.sv
verilog/hzd_regfile.sv
verilog/hzd_bypass_ctrl.sv
verilog/hzd_id_stage.sv
verilog/hzd_ex_stage.sv
verilog/hzd_wb_stage.sv
verilog/hzd_core.sv
bench/tb_mem_model.sv
bench/tb_core.sv

// ==== verilog/hzd_bypass_ctrl.sv ====
/*
 * Bypass and hazard controller. Compares the ID source registers against
 * the destinations in EX and WB, picks forward paths for both operands
 * and requests an ID stall for load-use hazards
 */
`timescale 1ns/1ps

module hzd_bypass_ctrl (
  input  logic              rf_re_a_i,
  input  logic              rf_re_b_i,
  input  hzd_pkg::rf_addr_t raddr_a_i,
  input  hzd_pkg::rf_addr_t raddr_b_i,
  input  logic              ex_valid_i,
  input  logic              ex_is_load_i,
  input  hzd_pkg::rf_addr_t ex_rd_i,
  input  logic              wb_valid_i,
  input  hzd_pkg::rf_addr_t wb_rd_i,
  input  logic              wb_ready_i,
  output logic              load_stall_o,
  output hzd_pkg::fw_sel_e  op_a_fw_sel_o,
  output hzd_pkg::fw_sel_e  op_b_fw_sel_o
);

  // Index 0 is operand A, index 1 is operand B
  logic [1:0]        rf_re;
  hzd_pkg::rf_addr_t raddr [2];

  // Address matches, not yet qualified with a valid writer in EX or WB
  logic [1:0]        rd_ex_match;
  logic [1:0]        rd_wb_match;
  hzd_pkg::fw_sel_e  fw_sel [2];

  assign rf_re    = {rf_re_b_i, rf_re_a_i};
  assign raddr[0] = raddr_a_i;
  assign raddr[1] = raddr_b_i;

  ////////////////////////////////////////////////////////////////////////////
  // Hazard detection
  ////////////////////////////////////////////////////////////////////////////

  // Register zero never matches since it always reads as zero
  for (genvar i = 0; i < 2; i++) begin : gen_match
    assign rd_ex_match[i] = rf_re[i] && (raddr[i] != '0) && (raddr[i] == ex_rd_i);
    assign rd_wb_match[i] = rf_re[i] && (raddr[i] != '0) && (raddr[i] == wb_rd_i);
  end

  // A load in EX has no data yet, and neither has a load waiting on memory in WB
  // Both cases hold ID and send a bubble into EX
  assign load_stall_o = (ex_valid_i && ex_is_load_i && (|rd_ex_match)) ||
                        (wb_valid_i && !wb_ready_i && (|rd_wb_match));

  ////////////////////////////////////////////////////////////////////////////
  // Forward select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      fw_sel[i] = hzd_pkg::FW_REGFILE;
      if (wb_valid_i && rd_wb_match[i]) begin
        fw_sel[i] = hzd_pkg::FW_WB;
      end
      // EX holds the younger write, so it overrides WB
      if (ex_valid_i && rd_ex_match[i]) begin
        fw_sel[i] = hzd_pkg::FW_EX;
      end
    end
  end

  assign op_a_fw_sel_o = fw_sel[0];
  assign op_b_fw_sel_o = fw_sel[1];

endmodule

// ==== verilog/hzd_core.sv ====
/*
 * Top level of the three-stage pipeline. Connects ID, EX and WB with the
 * register file and the bypass controller
 */
`timescale 1ns/1ps

module hzd_core (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              instr_valid_i,
  input  hzd_pkg::op_e      op_i,
  input  hzd_pkg::rf_addr_t rd_i,
  input  hzd_pkg::rf_addr_t rs1_i,
  input  hzd_pkg::rf_addr_t rs2_i,
  input  hzd_pkg::xlen_t    imm_i,
  output logic              instr_ready_o,
  output logic              mem_req_o,
  output hzd_pkg::xlen_t    mem_addr_o,
  input  logic              mem_ack_i,
  input  hzd_pkg::xlen_t    mem_rdata_i,
  output logic              wb_valid_o,
  output hzd_pkg::rf_addr_t wb_rd_o,
  output hzd_pkg::xlen_t    wb_data_o
);

  // ID to register file and bypass controller
  logic              rf_re_a;
  logic              rf_re_b;
  hzd_pkg::rf_addr_t raddr_a;
  hzd_pkg::rf_addr_t raddr_b;
  hzd_pkg::xlen_t    rf_rdata_a;
  hzd_pkg::xlen_t    rf_rdata_b;

  // Bypass controller back to ID
  logic              load_stall;
  hzd_pkg::fw_sel_e  op_a_fw_sel;
  hzd_pkg::fw_sel_e  op_b_fw_sel;

  // ID/EX register
  logic              id_ex_valid;
  hzd_pkg::op_e      id_ex_op;
  hzd_pkg::rf_addr_t id_ex_rd;
  hzd_pkg::xlen_t    id_ex_opa;
  hzd_pkg::xlen_t    id_ex_opb;

  // EX hazard view and forward data
  logic              ex_ready;
  logic              ex_is_load;
  hzd_pkg::rf_addr_t ex_rd;
  logic              ex_valid;
  hzd_pkg::xlen_t    ex_result;

  // EX/WB register
  logic              ex_wb_valid;
  logic              ex_wb_is_load;
  hzd_pkg::rf_addr_t ex_wb_rd;
  hzd_pkg::xlen_t    ex_wb_value;

  // WB status and register write
  logic              wb_ready;
  logic              wb_busy_rd_valid;
  logic              rf_we;
  hzd_pkg::rf_addr_t rf_waddr;
  hzd_pkg::xlen_t    rf_wdata;

  hzd_id_stage u_id_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .op_i          (op_i),
    .rd_i          (rd_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .imm_i         (imm_i),
    .instr_ready_o (instr_ready_o),
    .rf_re_a_o     (rf_re_a),
    .rf_re_b_o     (rf_re_b),
    .raddr_a_o     (raddr_a),
    .raddr_b_o     (raddr_b),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .op_a_fw_sel_i (op_a_fw_sel),
    .op_b_fw_sel_i (op_b_fw_sel),
    .load_stall_i  (load_stall),
    .ex_result_i   (ex_result),
    .wb_data_i     (rf_wdata),
    .ex_ready_i    (ex_ready),
    .ex_valid_o    (id_ex_valid),
    .ex_op_o       (id_ex_op),
    .ex_rd_o       (id_ex_rd),
    .ex_opa_o      (id_ex_opa),
    .ex_opb_o      (id_ex_opb)
  );

  hzd_ex_stage u_ex_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .valid_i      (id_ex_valid),
    .op_i         (id_ex_op),
    .rd_i         (id_ex_rd),
    .opa_i        (id_ex_opa),
    .opb_i        (id_ex_opb),
    .wb_ready_i   (wb_ready),
    .ready_o      (ex_ready),
    .is_load_o    (ex_is_load),
    .rd_o         (ex_rd),
    .valid_o      (ex_valid),
    .result_o     (ex_result),
    .wb_valid_o   (ex_wb_valid),
    .wb_is_load_o (ex_wb_is_load),
    .wb_rd_o      (ex_wb_rd),
    .wb_value_o   (ex_wb_value)
  );

  hzd_wb_stage u_wb_stage (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .valid_i         (ex_wb_valid),
    .is_load_i       (ex_wb_is_load),
    .rd_i            (ex_wb_rd),
    .value_i         (ex_wb_value),
    .ready_o         (wb_ready),
    .busy_rd_valid_o (wb_busy_rd_valid),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rdata_i     (mem_rdata_i),
    .rf_we_o         (rf_we),
    .rf_waddr_o      (rf_waddr),
    .rf_wdata_o      (rf_wdata)
  );

  hzd_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  hzd_bypass_ctrl u_bypass_ctrl (
    .rf_re_a_i     (rf_re_a),
    .rf_re_b_i     (rf_re_b),
    .raddr_a_i     (raddr_a),
    .raddr_b_i     (raddr_b),
    .ex_valid_i    (ex_valid),
    .ex_is_load_i  (ex_is_load),
    .ex_rd_i       (ex_rd),
    .wb_valid_i    (wb_busy_rd_valid),
    .wb_rd_i       (rf_waddr),
    .wb_ready_i    (wb_ready),
    .load_stall_o  (load_stall),
    .op_a_fw_sel_o (op_a_fw_sel),
    .op_b_fw_sel_o (op_b_fw_sel)
  );

  // Every register write is visible on the observation port
  assign wb_valid_o = rf_we;
  assign wb_rd_o    = rf_waddr;
  assign wb_data_o  = rf_wdata;

endmodule

// ==== verilog/hzd_ex_stage.sv ====
/*
 * Execute stage. One adder produces both the ALU result and the load
 * address; the result feeds the EX forward path and the EX/WB register
 */
`timescale 1ns/1ps

module hzd_ex_stage (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  hzd_pkg::op_e      op_i,
  input  hzd_pkg::rf_addr_t rd_i,
  input  hzd_pkg::xlen_t    opa_i,
  input  hzd_pkg::xlen_t    opb_i,
  input  logic              wb_ready_i,
  output logic              ready_o,
  output logic              is_load_o,
  output hzd_pkg::rf_addr_t rd_o,
  output logic              valid_o,
  output hzd_pkg::xlen_t    result_o,
  output logic              wb_valid_o,
  output logic              wb_is_load_o,
  output hzd_pkg::rf_addr_t wb_rd_o,
  output hzd_pkg::xlen_t    wb_value_o
);

  // All three opcodes are an add of the two operands
  assign result_o = opa_i + opb_i;

  // EX only moves when WB can take its instruction
  assign ready_o = wb_ready_i;

  // Hazard view of EX for the bypass controller
  // A destination of register zero is never a hazard
  assign is_load_o = (op_i == hzd_pkg::OP_LOAD);
  assign rd_o      = rd_i;
  assign valid_o   = valid_i && (rd_i != '0);

  // EX/WB register holds its content while WB waits on memory
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_valid_o <= 1'b0;
    end else if (wb_ready_i) begin
      wb_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_ready_i && valid_i) begin
      wb_is_load_o <= is_load_o;
      wb_rd_o      <= rd_i;
      wb_value_o   <= result_o;
    end
  end

endmodule

// ==== verilog/hzd_id_stage.sv ====
/*
 * Instruction decode stage. Accepts pre-decoded instructions over
 * valid/ready, reads the register file, resolves operand forwarding and
 * fills the ID/EX pipeline register
 */
`timescale 1ns/1ps

module hzd_id_stage (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              instr_valid_i,
  input  hzd_pkg::op_e      op_i,
  input  hzd_pkg::rf_addr_t rd_i,
  input  hzd_pkg::rf_addr_t rs1_i,
  input  hzd_pkg::rf_addr_t rs2_i,
  input  hzd_pkg::xlen_t    imm_i,
  output logic              instr_ready_o,
  output logic              rf_re_a_o,
  output logic              rf_re_b_o,
  output hzd_pkg::rf_addr_t raddr_a_o,
  output hzd_pkg::rf_addr_t raddr_b_o,
  input  hzd_pkg::xlen_t    rf_rdata_a_i,
  input  hzd_pkg::xlen_t    rf_rdata_b_i,
  input  hzd_pkg::fw_sel_e  op_a_fw_sel_i,
  input  hzd_pkg::fw_sel_e  op_b_fw_sel_i,
  input  logic              load_stall_i,
  input  hzd_pkg::xlen_t    ex_result_i,
  input  hzd_pkg::xlen_t    wb_data_i,
  input  logic              ex_ready_i,
  output logic              ex_valid_o,
  output hzd_pkg::op_e      ex_op_o,
  output hzd_pkg::rf_addr_t ex_rd_o,
  output hzd_pkg::xlen_t    ex_opa_o,
  output hzd_pkg::xlen_t    ex_opb_o
);

  // Instruction currently held in ID
  logic              id_valid_q;
  hzd_pkg::op_e      id_op_q;
  hzd_pkg::rf_addr_t id_rd_q;
  hzd_pkg::rf_addr_t id_rs1_q;
  hzd_pkg::rf_addr_t id_rs2_q;
  hzd_pkg::xlen_t    id_imm_q;

  logic              id_issue;
  hzd_pkg::xlen_t    fw_a;
  hzd_pkg::xlen_t    fw_b;
  hzd_pkg::xlen_t    opb;

  // Operand source mux shared by both read ports
  function automatic hzd_pkg::xlen_t fw_mux(hzd_pkg::fw_sel_e sel,
                                            hzd_pkg::xlen_t   rf_val,
                                            hzd_pkg::xlen_t   ex_val,
                                            hzd_pkg::xlen_t   wb_val);
    case (sel)
      hzd_pkg::FW_EX: return ex_val;
      hzd_pkg::FW_WB: return wb_val;
      default:        return rf_val;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Register reads and operand selection
  ////////////////////////////////////////////////////////////////////////////

  // Every opcode reads rs1; only add reads rs2
  assign rf_re_a_o = id_valid_q;
  assign rf_re_b_o = id_valid_q && (id_op_q == hzd_pkg::OP_ADD);
  assign raddr_a_o = id_rs1_q;
  assign raddr_b_o = id_rs2_q;

  assign fw_a = fw_mux(op_a_fw_sel_i, rf_rdata_a_i, ex_result_i, wb_data_i);
  assign fw_b = fw_mux(op_b_fw_sel_i, rf_rdata_b_i, ex_result_i, wb_data_i);

  // Add-immediate and load take the immediate as operand B
  assign opb = (id_op_q == hzd_pkg::OP_ADD) ? fw_b : id_imm_q;

  ////////////////////////////////////////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////////////////////////////////////////

  // ID can take a new instruction whenever its current one leaves or it is empty
  // load_stall_i is only raised for a valid instruction, so an empty ID never stalls
  assign instr_ready_o = ex_ready_i && !load_stall_i;
  assign id_issue      = id_valid_q && instr_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_valid_q <= 1'b0;
    end else if (instr_ready_o) begin
      id_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_ready_o && instr_valid_i) begin
      id_op_q  <= op_i;
      id_rd_q  <= rd_i;
      id_rs1_q <= rs1_i;
      id_rs2_q <= rs2_i;
      id_imm_q <= imm_i;
    end
  end

  // ID/EX register. While EX is ready a stalled ID turns into a bubble
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_valid_o <= 1'b0;
    end else if (ex_ready_i) begin
      ex_valid_o <= id_issue;
    end
  end

  always_ff @(posedge clk_i) begin
    if (id_issue) begin
      ex_op_o  <= id_op_q;
      ex_rd_o  <= id_rd_q;
      ex_opa_o <= fw_a;
      ex_opb_o <= opb;
    end
  end

endmodule

// ==== verilog/hzd_pkg.sv ====
/*
 * Shared definitions for the three-stage integer pipeline: data and
 * register-index widths, opcode encoding and operand forward-select encoding
 */
package hzd_pkg;

  // Width of a data word and of every operand
  localparam int unsigned XLEN = 32;

  // Register index width, giving 32 architectural registers
  localparam int unsigned RF_ADDR_W = 5;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  // Pre-decoded instructions delivered on the instruction port
  // OP_ADD writes rs1 + rs2
  // OP_ADDI writes rs1 + imm
  // OP_LOAD writes the memory word found at rs1 + imm
  typedef enum logic [1:0] {
    OP_ADD  = 2'd0,
    OP_ADDI = 2'd1,
    OP_LOAD = 2'd2
  } op_e;

  // Source of an ID operand as chosen by the bypass controller
  typedef enum logic [1:0] {
    FW_REGFILE = 2'd0,
    FW_EX      = 2'd1,
    FW_WB      = 2'd2
  } fw_sel_e;

endpackage

// ==== verilog/hzd_regfile.sv ====
/*
 * Integer register file with two combinational read ports and one write
 * port. Register zero is hardwired to zero
 */
`timescale 1ns/1ps

module hzd_regfile (
  input  logic              clk_i,
  input  logic              rst_i,
  input  hzd_pkg::rf_addr_t raddr_a_i,
  input  hzd_pkg::rf_addr_t raddr_b_i,
  output hzd_pkg::xlen_t    rdata_a_o,
  output hzd_pkg::xlen_t    rdata_b_o,
  input  logic              we_i,
  input  hzd_pkg::rf_addr_t waddr_i,
  input  hzd_pkg::xlen_t    wdata_i
);

  // Only entries 1 to 31 have storage
  hzd_pkg::xlen_t regs_q [1:2**hzd_pkg::RF_ADDR_W-1];

  // All writable registers clear on reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < 2**hzd_pkg::RF_ADDR_W; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // A write to register zero is dropped here
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads are combinational, so a write in the same cycle is not visible yet
  // The WB forward path supplies that value to ID instead
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== verilog/hzd_wb_stage.sv ====
/*
 * Write-back stage. ALU results retire in their first WB cycle; loads run
 * a four-phase req/ack access to data memory and retire once ack has
 * dropped again. The register write also feeds the ID forward path
 */
`timescale 1ns/1ps

module hzd_wb_stage (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              valid_i,
  input  logic              is_load_i,
  input  hzd_pkg::rf_addr_t rd_i,
  input  hzd_pkg::xlen_t    value_i,
  output logic              ready_o,
  output logic              busy_rd_valid_o,
  output logic              mem_req_o,
  output hzd_pkg::xlen_t    mem_addr_o,
  input  logic              mem_ack_i,
  input  hzd_pkg::xlen_t    mem_rdata_i,
  output logic              rf_we_o,
  output hzd_pkg::rf_addr_t rf_waddr_o,
  output hzd_pkg::xlen_t    rf_wdata_o
);

  // WB_REQ holds req high until ack and WB_RELEASE waits for ack to drop
  typedef enum logic [1:0] {
    WB_IDLE    = 2'd0,
    WB_REQ     = 2'd1,
    WB_RELEASE = 2'd2
  } wb_state_e;

  wb_state_e      state_q;
  wb_state_e      state_d;
  logic           load_done_q;
  logic           load_done_d;
  logic           load_wb;
  hzd_pkg::xlen_t load_data_q;

  assign load_wb = valid_i && is_load_i;

  ////////////////////////////////////////////////////////////////////////////
  // Four-phase load FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    load_done_d = load_done_q;
    case (state_q)
      WB_IDLE: begin
        if (load_wb) begin
          if (load_done_q) begin
            // Load retires in this cycle
            load_done_d = 1'b0;
          end else if (!mem_ack_i) begin
            // Req may only rise once ack from the previous access is low
            state_d = WB_REQ;
          end
        end
      end
      WB_REQ: begin
        if (mem_ack_i) begin
          state_d = WB_RELEASE;
        end
      end
      WB_RELEASE: begin
        if (!mem_ack_i) begin
          state_d     = WB_IDLE;
          load_done_d = 1'b1;
        end
      end
      default: begin
        state_d = WB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= WB_IDLE;
      load_done_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      load_done_q <= load_done_d;
    end
  end

  // Read data is taken on the first edge with ack high
  always_ff @(posedge clk_i) begin
    if ((state_q == WB_REQ) && mem_ack_i) begin
      load_data_q <= mem_rdata_i;
    end
  end

  // The address comes straight from EX/WB, which is frozen during the access
  assign mem_req_o  = (state_q == WB_REQ);
  assign mem_addr_o = value_i;

  ////////////////////////////////////////////////////////////////////////////
  // Register write-back
  ////////////////////////////////////////////////////////////////////////////

  // WB blocks the pipeline for the whole load access
  assign ready_o = !load_wb || load_done_q;

  // The destination stays visible to the bypass controller while WB waits
  assign busy_rd_valid_o = valid_i && (rd_i != '0);

  assign rf_we_o    = valid_i && ready_o && (rd_i != '0);
  assign rf_waddr_o = rd_i;
  assign rf_wdata_o = is_load_i ? load_data_q : value_i;

endmodule
